// File: sim/fm_reg_trace.txt
# W part addr data | O op ch tl dt1 mul ks ar keyon | H op ch fnum block fb alg rl ams pms
# A alg fb carrier_mask(bit0=S1..bit3=S4) fb_en_on_S1, all values hex
W 1 49 2a
O 2 5 2a 0 0 0 00 0
O 2 4 00 0 0 0 00 0
O 0 5 00 0 0 0 00 0
W 1 59 c7
O 2 5 2a 0 0 3 07 0
W 0 30 35
O 0 0 00 3 5 0 00 0
W 0 a5 22
H 0 1 000 0 0 0 3 0 0
W 0 a1 5c
H 0 1 25c 4 0 0 3 0 0
H 3 1 25c 4 0 0 3 0 0
W 1 b0 2d
W 1 b4 96
H 1 4 000 0 5 5 2 1 6
W 0 28 a5
O 0 5 00 0 0 0 00 0
O 2 5 2a 0 0 3 07 1
O 1 5 00 0 0 0 00 0
O 3 5 00 0 0 0 00 1
W 0 28 05
O 3 5 00 0 0 0 00 0
A 0 0 8 0
A 1 3 8 1
A 2 0 8 0
A 3 7 8 1
A 4 1 a 1
A 5 0 e 0
A 6 2 e 1
A 7 0 f 0

// File: tb.f
+incdir+hw
hw/fm_pkg.sv
hw/fm_write_port.sv
hw/fm_slot_seq.sv
hw/fm_op_regs.sv
hw/fm_ch_regs.sv
hw/fm_conn_decode.sv
hw/fm_reg_top.sv
sim/fm_reg_properties.sv
sim/fm_reg_tb.sv

// File: Makefile
TOP = fm_reg_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wall -f tb.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir

// File: sim/fm_reg_tb.sv
`timescale 1ns/1ps
`include "fm_settings.svh"

module fm_reg_tb;
    import fm_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        wr;
    logic        part;
    logic [7:0]  addr;
    logic [7:0]  din;
    logic        busy;
    op_idx_t     cur_op;
    ch_idx_t     cur_ch;
    logic        zero;
    logic        s1_enters;
    logic        s2_enters;
    logic        s3_enters;
    logic        s4_enters;
    logic [6:0]  tl;
    logic [2:0]  dt1;
    logic [3:0]  mul;
    logic [1:0]  ks;
    logic [4:0]  ar;
    logic        amen;
    logic [4:0]  d1r;
    logic [4:0]  d2r;
    logic [3:0]  sl;
    logic [3:0]  rr;
    logic        ssg_en;
    logic [2:0]  ssg_eg;
    logic        keyon;
    logic [10:0] fnum;
    logic [2:0]  block;
    logic [2:0]  fb;
    logic [2:0]  alg;
    logic [1:0]  rl;
    logic [1:0]  ams;
    logic [2:0]  pms;
    logic        carrier;
    logic        fb_en;

    string       lines[$];
    int          cycles;
    int          limit;

    fm_reg_top u_dut (
        .clk(clk), .rst_n(rst_n), .wr(wr), .part(part), .addr(addr), .din(din),
        .busy(busy), .cur_op(cur_op), .cur_ch(cur_ch), .zero(zero),
        .s1_enters(s1_enters), .s2_enters(s2_enters),
        .s3_enters(s3_enters), .s4_enters(s4_enters),
        .tl(tl), .dt1(dt1), .mul(mul), .ks(ks), .ar(ar), .amen(amen),
        .d1r(d1r), .d2r(d2r), .sl(sl), .rr(rr), .ssg_en(ssg_en),
        .ssg_eg(ssg_eg), .keyon(keyon), .fnum(fnum), .block(block),
        .fb(fb), .alg(alg), .rl(rl), .ams(ams), .pms(pms),
        .carrier(carrier), .fb_en(fb_en)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run length guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit != 0 && cycles > limit) begin
            $display("timeout after %0d cycles, DUT did not respond in time", cycles);
            $display("TEST FAILED");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    task automatic fail_value(string name, logic [31:0] got, logic [31:0] exp);
        $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
        $display("TEST FAILED");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic fail_plain(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare_slot(op_idx_t exp_op, ch_idx_t exp_ch);
        if (cur_op !== exp_op) fail_value("cur_op", 32'(cur_op), 32'(exp_op));
        if (cur_ch !== exp_ch) fail_value("cur_ch", 32'(cur_ch), 32'(exp_ch));
    endtask

    task automatic compare_field(string name, logic [10:0] got, logic [10:0] exp);
        if (got !== exp) fail_value(name, 32'(got), 32'(exp));
    endtask

    task automatic compare_flag(string name, logic got, logic exp);
        if (got !== exp) fail_value(name, 32'(got), 32'(exp));
    endtask

    task automatic compare_fbalg(ch_byte_u got, ch_byte_u exp);
        if (got.fbalg.fb !== exp.fbalg.fb) begin
            fail_value("fb", 32'(got.fbalg.fb), 32'(exp.fbalg.fb));
        end
        if (got.fbalg.alg !== exp.fbalg.alg) begin
            fail_value("alg", 32'(got.fbalg.alg), 32'(exp.fbalg.alg));
        end
    endtask

    task automatic compare_lrpms(ch_byte_u got, ch_byte_u exp);
        if (got.lrpms.lr !== exp.lrpms.lr) begin
            fail_value("rl", 32'(got.lrpms.lr), 32'(exp.lrpms.lr));
        end
        if (got.lrpms.ams !== exp.lrpms.ams) begin
            fail_value("ams", 32'(got.lrpms.ams), 32'(exp.lrpms.ams));
        end
        if (got.lrpms.pms !== exp.lrpms.pms) begin
            fail_value("pms", 32'(got.lrpms.pms), 32'(exp.lrpms.pms));
        end
    endtask

    // one register write, then hold off until the DUT is free again
    task automatic write_reg(logic p, logic [7:0] a, logic [7:0] d);
        int gap;
        @(posedge clk);
        wr   <= 1'b1;
        part <= p;
        addr <= a;
        din  <= d;
        @(posedge clk);
        wr <= 1'b0;
        @(negedge clk);
        if (!busy) fail_plain("write was not accepted, busy stayed low");
        while (busy) @(negedge clk);
        gap = $urandom % 4;
        repeat (gap) @(posedge clk);
    endtask

    // sample point is the falling edge, outputs settled
    task automatic wait_slot(op_idx_t op, ch_idx_t ch);
        int n;
        n = 0;
        @(negedge clk);
        while (!(cur_op == op && cur_ch == ch)) begin
            n++;
            if (n > 2 * `FM_SLOTS) fail_plain("requested slot never came around");
            @(negedge clk);
        end
    endtask

    task automatic reset_frame();
        int      zeros;
        ch_idx_t order[6];
        ch_byte_u got;
        ch_byte_u exp;
        order = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd6};
        zeros = 0;
        for (int i = 0; i < `FM_SLOTS; i++) begin
            @(negedge clk);
            compare_slot(op_idx_t'(i / 6), order[i % 6]);
            compare_flag("zero", zero, i == 0);
            if (zero) zeros++;
            // operators come in the order S1 S3 S2 S4
            compare_flag("s1_enters", s1_enters, i / 6 == 0);
            compare_flag("s3_enters", s3_enters, i / 6 == 1);
            compare_flag("s2_enters", s2_enters, i / 6 == 2);
            compare_flag("s4_enters", s4_enters, i / 6 == 3);
            compare_field("tl", 11'(tl), 11'd0);
            compare_field("dt1", 11'(dt1), 11'd0);
            compare_field("mul", 11'(mul), 11'd0);
            compare_field("ks", 11'(ks), 11'd0);
            compare_field("ar", 11'(ar), 11'd0);
            compare_flag("amen", amen, 1'b0);
            compare_field("d1r", 11'(d1r), 11'd0);
            compare_field("d2r", 11'(d2r), 11'd0);
            compare_field("sl", 11'(sl), 11'd0);
            compare_field("rr", 11'(rr), 11'd0);
            compare_flag("ssg_en", ssg_en, 1'b0);
            compare_field("ssg_eg", 11'(ssg_eg), 11'd0);
            compare_flag("keyon", keyon, 1'b0);
            compare_field("fnum", fnum, 11'd0);
            compare_field("block", 11'(block), 11'd0);
            got = {2'b00, fb, alg};
            exp = 8'h00;
            compare_fbalg(got, exp);
            got = {rl, ams, 1'b0, pms};
            exp = {2'b11, 2'b00, 1'b0, 3'd0};
            compare_lrpms(got, exp);
        end
        if (zeros != 1) fail_plain("zero did not pulse exactly once in the first frame");
    endtask

    task automatic run_line(string line);
        logic [31:0] v[9];
        ch_byte_u    got;
        ch_byte_u    exp;
        case (line.getc(0))
            "W": begin
                void'($sscanf(line, "W %h %h %h", v[0], v[1], v[2]));
                write_reg(v[0][0], v[1][7:0], v[2][7:0]);
            end
            // op ch tl dt1 mul ks ar keyon
            "O": begin
                void'($sscanf(line, "O %h %h %h %h %h %h %h %h",
                              v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]));
                wait_slot(op_idx_t'(v[0]), ch_idx_t'(v[1]));
                compare_field("tl", 11'(tl), v[2][10:0]);
                compare_field("dt1", 11'(dt1), v[3][10:0]);
                compare_field("mul", 11'(mul), v[4][10:0]);
                compare_field("ks", 11'(ks), v[5][10:0]);
                compare_field("ar", 11'(ar), v[6][10:0]);
                compare_flag("keyon", keyon, v[7][0]);
            end
            // op ch fnum block fb alg rl ams pms
            "H": begin
                void'($sscanf(line, "H %h %h %h %h %h %h %h %h %h", v[0], v[1],
                              v[2], v[3], v[4], v[5], v[6], v[7], v[8]));
                wait_slot(op_idx_t'(v[0]), ch_idx_t'(v[1]));
                compare_field("fnum", fnum, v[2][10:0]);
                compare_field("block", 11'(block), v[3][10:0]);
                got = {2'b00, fb, alg};
                exp = {2'b00, v[4][2:0], v[5][2:0]};
                compare_fbalg(got, exp);
                got = {rl, ams, 1'b0, pms};
                exp = {v[6][1:0], v[7][1:0], 1'b0, v[8][2:0]};
                compare_lrpms(got, exp);
            end
            // alg fb, carrier mask bit0 = S1 .. bit3 = S4, fb_en on S1
            "A": begin
                void'($sscanf(line, "A %h %h %h %h", v[0], v[1], v[2], v[3]));
                write_reg(1'b0, 8'hb0, {2'b00, v[1][2:0], v[0][2:0]});
                // S1 S3 S2 S4 is slot order, so one frame is enough
                wait_slot(2'b00, 3'd0);
                compare_flag("carrier", carrier, v[2][0]);
                compare_flag("fb_en", fb_en, v[3][0]);
                wait_slot(2'b01, 3'd0);
                compare_flag("carrier", carrier, v[2][2]);
                compare_flag("fb_en", fb_en, 1'b0);
                wait_slot(2'b10, 3'd0);
                compare_flag("carrier", carrier, v[2][1]);
                compare_flag("fb_en", fb_en, 1'b0);
                wait_slot(2'b11, 3'd0);
                compare_flag("carrier", carrier, v[2][3]);
                compare_flag("fb_en", fb_en, 1'b0);
            end
            default: fail_plain({"unknown trace command: ", line});
        endcase
    endtask

    initial begin
        int    fd;
        string line;
        void'($urandom(32'hae40aae4));
        cycles = 0;
        limit  = 0;
        rst_n  = 1'b0;
        wr     = 1'b0;
        part   = 1'b0;
        addr   = 8'h00;
        din    = 8'h00;
        fd = $fopen("sim/fm_reg_trace.txt", "r");
        if (fd == 0) fail_plain("cannot open the trace file");
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
        limit = (lines.size() + 2) * 60;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        reset_frame();
        foreach (lines[i]) begin
            run_line(lines[i]);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// File: sim/fm_reg_properties.sv
`timescale 1ns/1ps

module fm_reg_properties (
    input logic            clk,
    input logic            rst_n,
    input logic            wr,
    input logic            busy,
    input logic            zero,
    input fm_pkg::op_idx_t cur_op,
    input fm_pkg::ch_idx_t cur_ch,
    input logic            s1_enters,
    input logic            s2_enters,
    input logic            s3_enters,
    input logic            s4_enters
);

    a_entry_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot({s1_enters, s2_enters, s3_enters, s4_enters}))
        else $error("operator entry flags not one-hot");

    a_zero_pos: assert property (@(posedge clk) disable iff (!rst_n)
        zero == (cur_op == 2'd0 && cur_ch == 3'd0))
        else $error("zero flag out of place");

    // codes 3 and 7 are holes in the channel numbering
    a_ch_code: assert property (@(posedge clk) disable iff (!rst_n)
        cur_ch != 3'd3 && cur_ch != 3'd7)
        else $error("unused channel code on cur_ch");

    a_no_wr_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr && busy))
        else $error("write issued while busy");

endmodule

bind fm_reg_top fm_reg_properties u_props (
    .clk(clk), .rst_n(rst_n), .wr(wr), .busy(busy), .zero(zero),
    .cur_op(cur_op), .cur_ch(cur_ch), .s1_enters(s1_enters),
    .s2_enters(s2_enters), .s3_enters(s3_enters), .s4_enters(s4_enters)
);

// File: hw/fm_reg_top.sv
`timescale 1ns/1ps
`include "fm_settings.svh"

module fm_reg_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            wr,
    input  logic            part,
    input  logic [7:0]      addr,
    input  logic [7:0]      din,
    output logic            busy,
    output fm_pkg::op_idx_t cur_op,
    output fm_pkg::ch_idx_t cur_ch,
    output logic            zero,
    output logic            s1_enters,
    output logic            s2_enters,
    output logic            s3_enters,
    output logic            s4_enters,
    output logic [6:0]      tl,
    output logic [2:0]      dt1,
    output logic [3:0]      mul,
    output logic [1:0]      ks,
    output logic [4:0]      ar,
    output logic            amen,
    output logic [4:0]      d1r,
    output logic [4:0]      d2r,
    output logic [3:0]      sl,
    output logic [3:0]      rr,
    output logic            ssg_en,
    output logic [2:0]      ssg_eg,
    output logic            keyon,
    output logic [10:0]     fnum,
    output logic [2:0]      block,
    output logic [2:0]      fb,
    output logic [2:0]      alg,
    output logic [1:0]      rl,
    output logic [1:0]      ams,
    output logic [2:0]      pms,
    output logic            carrier,
    output logic            fb_en
);
    import fm_pkg::*;

    logic [`FM_OP_GROUPS-1:0] up_op_grp;
    logic                     up_fnum_lo;
    logic                     up_fnum_hi;
    logic                     up_fb_alg;
    logic                     up_lr_pms;
    logic                     up_keyon;
    op_idx_t                  tgt_op;
    ch_idx_t                  tgt_ch;
    logic [7:0]               wdata;

    fm_write_port u_write_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr         (wr),
        .part       (part),
        .addr       (addr),
        .din        (din),
        .busy       (busy),
        .up_op_grp  (up_op_grp),
        .up_fnum_lo (up_fnum_lo),
        .up_fnum_hi (up_fnum_hi),
        .up_fb_alg  (up_fb_alg),
        .up_lr_pms  (up_lr_pms),
        .up_keyon   (up_keyon),
        .tgt_op     (tgt_op),
        .tgt_ch     (tgt_ch),
        .wdata      (wdata)
    );

    fm_slot_seq u_slot_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .cur_op    (cur_op),
        .cur_ch    (cur_ch),
        .zero      (zero),
        .s1_enters (s1_enters),
        .s2_enters (s2_enters),
        .s3_enters (s3_enters),
        .s4_enters (s4_enters)
    );

    fm_op_regs u_op_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cur_op    (cur_op),
        .cur_ch    (cur_ch),
        .up_op_grp (up_op_grp),
        .up_keyon  (up_keyon),
        .tgt_op    (tgt_op),
        .tgt_ch    (tgt_ch),
        .wdata     (wdata),
        .tl        (tl),
        .dt1       (dt1),
        .mul       (mul),
        .ks        (ks),
        .ar        (ar),
        .amen      (amen),
        .d1r       (d1r),
        .d2r       (d2r),
        .sl        (sl),
        .rr        (rr),
        .ssg_en    (ssg_en),
        .ssg_eg    (ssg_eg),
        .keyon     (keyon)
    );

    fm_ch_regs u_ch_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .cur_op     (cur_op),
        .cur_ch     (cur_ch),
        .up_fnum_lo (up_fnum_lo),
        .up_fnum_hi (up_fnum_hi),
        .up_fb_alg  (up_fb_alg),
        .up_lr_pms  (up_lr_pms),
        .tgt_ch     (tgt_ch),
        .wdata      (wdata),
        .fnum       (fnum),
        .block      (block),
        .fb         (fb),
        .alg        (alg),
        .rl         (rl),
        .ams        (ams),
        .pms        (pms)
    );

    fm_conn_decode u_conn (
        .alg       (alg),
        .s1_enters (s1_enters),
        .s2_enters (s2_enters),
        .s3_enters (s3_enters),
        .s4_enters (s4_enters),
        .fb        (fb),
        .carrier   (carrier),
        .fb_en     (fb_en)
    );

endmodule

// File: hw/fm_conn_decode.sv
`timescale 1ns/1ps

module fm_conn_decode (
    input  logic [2:0] alg,
    input  logic       s1_enters,
    input  logic       s2_enters,
    input  logic       s3_enters,
    input  logic       s4_enters,
    input  logic [2:0] fb,
    output logic       carrier,
    output logic       fb_en
);

    // which operators reach the output for each algorithm
    always_comb begin
        case (alg)
            3'd0, 3'd1, 3'd2, 3'd3: begin
                carrier = s4_enters;
            end
            3'd4: begin
                carrier = s2_enters || s4_enters;
            end
            3'd5, 3'd6: begin
                carrier = s2_enters || s3_enters || s4_enters;
            end
            default: begin
                // all four in parallel
                carrier = s1_enters || s2_enters || s3_enters || s4_enters;
            end
        endcase
    end

    // only S1 feeds back on itself
    assign fb_en = s1_enters && fb != 3'd0;

endmodule

// File: hw/fm_ch_regs.sv
`timescale 1ns/1ps
`include "fm_settings.svh"

module fm_ch_regs (
    input  logic            clk,
    input  logic            rst_n,
    input  fm_pkg::op_idx_t cur_op,
    input  fm_pkg::ch_idx_t cur_ch,
    input  logic            up_fnum_lo,
    input  logic            up_fnum_hi,
    input  logic            up_fb_alg,
    input  logic            up_lr_pms,
    input  fm_pkg::ch_idx_t tgt_ch,
    input  logic [7:0]      wdata,
    output logic [10:0]     fnum,
    output logic [2:0]      block,
    output logic [2:0]      fb,
    output logic [2:0]      alg,
    output logic [1:0]      rl,
    output logic [1:0]      ams,
    output logic [2:0]      pms
);
    import fm_pkg::*;

    // stereo defaults to both sides on
    localparam logic [`FM_CH_WIDTH-1:0] RST_REC = {{(`FM_CH_WIDTH - 7){1'b0}}, 2'b11, 5'b0};

    logic [`FM_CH_WIDTH-1:0] ring [`FM_CHANNELS];
    logic [`FM_CH_WIDTH-1:0] head;
    logic [`FM_CH_WIDTH-1:0] rec_in;
    logic [5:0]              fnum_hi_latch;
    logic                    hit;
    ch_byte_u                wbyte;

    assign head  = ring[0];
    assign {block, fnum, fb, alg, rl, ams, pms} = head;
    assign wbyte = wdata;
    assign hit   = cur_op == 2'b00 && cur_ch == tgt_ch;

    // block and fnum high wait here for the low byte
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fnum_hi_latch <= '0;
        end else if (up_fnum_hi) begin
            fnum_hi_latch <= wdata[5:0];
        end
    end

    always_comb begin
        rec_in = head;
        if (hit && up_fnum_lo) begin
            rec_in[26:13] = {fnum_hi_latch, wdata};
        end
        if (hit && up_fb_alg) begin
            rec_in[12:10] = wbyte.fbalg.fb;
            rec_in[9:7]   = wbyte.fbalg.alg;
        end
        if (hit && up_lr_pms) begin
            rec_in[6:5] = wbyte.lrpms.lr;
            rec_in[4:3] = wbyte.lrpms.ams;
            rec_in[2:0] = wbyte.lrpms.pms;
        end
    end

    // one step per slot, six steps bring a channel back around
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `FM_CHANNELS; i++) begin
                ring[i] <= RST_REC;
            end
        end else begin
            for (int i = 0; i < `FM_CHANNELS - 1; i++) begin
                ring[i] <= ring[i+1];
            end
            ring[`FM_CHANNELS-1] <= rec_in;
        end
    end

endmodule

// File: hw/fm_op_regs.sv
`timescale 1ns/1ps
`include "fm_settings.svh"

module fm_op_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  fm_pkg::op_idx_t           cur_op,
    input  fm_pkg::ch_idx_t           cur_ch,
    input  logic [`FM_OP_GROUPS-1:0]  up_op_grp,
    input  logic                      up_keyon,
    input  fm_pkg::op_idx_t           tgt_op,
    input  fm_pkg::ch_idx_t           tgt_ch,
    input  logic [7:0]                wdata,
    output logic [6:0]                tl,
    output logic [2:0]                dt1,
    output logic [3:0]                mul,
    output logic [1:0]                ks,
    output logic [4:0]                ar,
    output logic                      amen,
    output logic [4:0]                d1r,
    output logic [4:0]                d2r,
    output logic [3:0]                sl,
    output logic [3:0]                rr,
    output logic                      ssg_en,
    output logic [2:0]                ssg_eg,
    output logic                      keyon
);
    // bit 44 is the key-on flag, the rest the parameter record
    logic [`FM_OP_WIDTH:0]   ring [`FM_SLOTS];
    logic [`FM_OP_WIDTH:0]   head;
    logic [`FM_OP_WIDTH-1:0] rec_in;
    logic                    key_in;
    logic                    op_hit;
    logic                    ch_hit;
    logic                    mask_bit;

    assign head = ring[0];
    assign {keyon, tl, dt1, mul, ks, ar, amen, d1r, d2r, sl, rr, ssg_en, ssg_eg} = head;

    assign ch_hit = cur_ch == tgt_ch;
    assign op_hit = ch_hit && cur_op == tgt_op;

    // mask order in the data byte is S1 S2 S3 S4
    always_comb begin
        case (cur_op)
            2'b00:   mask_bit = wdata[4];
            2'b10:   mask_bit = wdata[5];
            2'b01:   mask_bit = wdata[6];
            default: mask_bit = wdata[7];
        endcase
    end

    always_comb begin
        rec_in = head[`FM_OP_WIDTH-1:0];
        if (op_hit) begin
            if (up_op_grp[0]) begin
                rec_in[33:30] = wdata[3:0];
                rec_in[36:34] = wdata[6:4];
            end
            if (up_op_grp[1]) rec_in[43:37] = wdata[6:0];
            if (up_op_grp[2]) begin
                rec_in[29:28] = wdata[7:6];
                rec_in[27:23] = wdata[4:0];
            end
            if (up_op_grp[3]) begin
                rec_in[22]    = wdata[7];
                rec_in[21:17] = wdata[4:0];
            end
            if (up_op_grp[4]) rec_in[16:12] = wdata[4:0];
            if (up_op_grp[5]) begin
                rec_in[11:8] = wdata[7:4];
                rec_in[7:4]  = wdata[3:0];
            end
            if (up_op_grp[6]) rec_in[3:0] = wdata[3:0];
        end
        key_in = (up_keyon && ch_hit) ? mask_bit : head[`FM_OP_WIDTH];
    end

    // head leaves, tail takes the possibly rewritten record
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `FM_SLOTS; i++) begin
                ring[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `FM_SLOTS - 1; i++) begin
                ring[i] <= ring[i+1];
            end
            ring[`FM_SLOTS-1] <= {key_in, rec_in};
        end
    end

endmodule

// File: hw/fm_slot_seq.sv
`timescale 1ns/1ps

module fm_slot_seq (
    input  logic            clk,
    input  logic            rst_n,
    output fm_pkg::op_idx_t cur_op,
    output fm_pkg::ch_idx_t cur_ch,
    output logic            zero,
    output logic            s1_enters,
    output logic            s2_enters,
    output logic            s3_enters,
    output logic            s4_enters
);
    import fm_pkg::*;

    op_idx_t next_op;
    ch_idx_t next_ch;

    // channel order 0 1 2 4 5 6, operator moves on after ch 6
    always_comb begin
        next_op = (cur_ch == 3'd6) ? cur_op + 2'd1 : cur_op;
        if (cur_ch == 3'd2) begin
            next_ch = 3'd4;
        end else if (cur_ch == 3'd6) begin
            next_ch = 3'd0;
        end else begin
            next_ch = cur_ch + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cur_op <= '0;
            cur_ch <= '0;
            zero   <= 1'b1;
        end else begin
            cur_op <= next_op;
            cur_ch <= next_ch;
            zero   <= next_op == 2'd0 && next_ch == 3'd0;
        end
    end

    // note S2 and S3 are swapped in the op code
    assign s1_enters = cur_op == 2'b00;
    assign s3_enters = cur_op == 2'b01;
    assign s2_enters = cur_op == 2'b10;
    assign s4_enters = cur_op == 2'b11;

endmodule

// File: hw/fm_write_port.sv
`timescale 1ns/1ps
`include "fm_settings.svh"

module fm_write_port (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wr,
    input  logic                      part,
    input  logic [7:0]                addr,
    input  logic [7:0]                din,
    output logic                      busy,
    output logic [`FM_OP_GROUPS-1:0]  up_op_grp,
    output logic                      up_fnum_lo,
    output logic                      up_fnum_hi,
    output logic                      up_fb_alg,
    output logic                      up_lr_pms,
    output logic                      up_keyon,
    output fm_pkg::op_idx_t           tgt_op,
    output fm_pkg::ch_idx_t           tgt_ch,
    output logic [7:0]                wdata
);
    import fm_pkg::*;

    localparam int CNT_W = $clog2(`FM_BUSY_CYCLES + 1);

    logic [CNT_W-1:0]         cnt;
    logic                     accept;
    logic                     ch_ok;
    logic [3:0]               grp;
    logic [`FM_OP_GROUPS-1:0] d_op_grp;
    logic                     d_fnum_lo;
    logic                     d_fnum_hi;
    logic                     d_fb_alg;
    logic                     d_lr_pms;
    logic                     d_keyon;
    op_idx_t                  d_op;
    ch_idx_t                  d_ch;

    assign accept = wr && !busy;
    assign busy   = cnt != '0;
    assign grp    = addr[7:4];
    // low bits 11 select no channel
    assign ch_ok  = addr[1:0] != 2'b11;

    always_comb begin
        d_op_grp  = '0;
        d_fnum_lo = 1'b0;
        d_fnum_hi = 1'b0;
        d_fb_alg  = 1'b0;
        d_lr_pms  = 1'b0;
        d_keyon   = 1'b0;
        d_op      = op_idx_t'(addr[3:2]);
        d_ch      = ch_idx_t'({part, addr[1:0]});
        if (grp >= `FM_GRP_DT1_MUL && grp <= `FM_GRP_SSG && ch_ok) begin
            d_op_grp[3'(grp - `FM_GRP_DT1_MUL)] = 1'b1;
        end
        if (grp == `FM_GRP_CH_A && !addr[3] && ch_ok) begin
            d_fnum_lo = !addr[2];
            d_fnum_hi = addr[2];
        end
        if (grp == `FM_GRP_CH_B && !addr[3] && ch_ok) begin
            d_fb_alg = !addr[2];
            d_lr_pms = addr[2];
        end
        // key-on takes its channel from the data byte
        if (!part && addr == `FM_ADDR_KEYON) begin
            d_keyon = 1'b1;
            d_ch    = ch_idx_t'(din[2:0]);
        end
    end

    // strobes live exactly as long as busy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt        <= '0;
            up_op_grp  <= '0;
            up_fnum_lo <= 1'b0;
            up_fnum_hi <= 1'b0;
            up_fb_alg  <= 1'b0;
            up_lr_pms  <= 1'b0;
            up_keyon   <= 1'b0;
        end else if (accept) begin
            cnt        <= CNT_W'(`FM_BUSY_CYCLES);
            up_op_grp  <= d_op_grp;
            up_fnum_lo <= d_fnum_lo;
            up_fnum_hi <= d_fnum_hi;
            up_fb_alg  <= d_fb_alg;
            up_lr_pms  <= d_lr_pms;
            up_keyon   <= d_keyon;
        end else if (busy) begin
            cnt <= cnt - 1'b1;
            if (cnt == CNT_W'(1)) begin
                up_op_grp  <= '0;
                up_fnum_lo <= 1'b0;
                up_fnum_hi <= 1'b0;
                up_fb_alg  <= 1'b0;
                up_lr_pms  <= 1'b0;
                up_keyon   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tgt_op <= d_op;
            tgt_ch <= d_ch;
            wdata  <= din;
        end
    end

endmodule

// File: hw/fm_pkg.sv
package fm_pkg;

    // operator position inside a channel
    // 00 = S1, 01 = S3, 10 = S2, 11 = S4
    typedef logic [1:0] op_idx_t;

    // channel code, 0..2 part 0, 4..6 part 1
    typedef logic [2:0] ch_idx_t;

    // register B0..B2 layout
    typedef struct packed {
        logic [1:0] unused;
        logic [2:0] fb;
        logic [2:0] alg;
    } fb_alg_t;

    // register B4..B6 layout
    typedef struct packed {
        logic [1:0] lr;
        logic [1:0] ams;
        logic       unused;
        logic [2:0] pms;
    } lr_pms_t;

    // one channel data byte, read through the view of its group
    typedef union packed {
        fb_alg_t fbalg;
        lr_pms_t lrpms;
    } ch_byte_u;

endpackage

// File: hw/fm_settings.svh
`ifndef FM_SETTINGS_SVH
`define FM_SETTINGS_SVH

// frame layout
`define FM_SLOTS        24
`define FM_CHANNELS     6

// ring record widths, key-on bit not included
`define FM_OP_WIDTH     44
`define FM_CH_WIDTH     27

// write hold time, one full frame
`define FM_BUSY_CYCLES  24

// operator groups, codes must stay consecutive
`define FM_OP_GROUPS    7
`define FM_GRP_DT1_MUL  4'h3
`define FM_GRP_TL       4'h4
`define FM_GRP_KS_AR    4'h5
`define FM_GRP_AMEN_D1R 4'h6
`define FM_GRP_D2R      4'h7
`define FM_GRP_SL_RR    4'h8
`define FM_GRP_SSG      4'h9

// channel groups
`define FM_GRP_CH_A     4'hA
`define FM_GRP_CH_B     4'hB

`define FM_ADDR_KEYON   8'h28

`endif
